//--- logic/tscroll_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile-scroll video package
// Shared scan, tilemap, tile ROM and pixel types plus the
// CPU address map of the tilemap windows and registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tscroll_pkg;

    // Raster position
    typedef logic [8:0]  hpos_t;
    typedef logic [8:0]  vpos_t;

    // Row[4:0] above column[4:0] of a 32x32 map
    typedef logic [9:0]  map_addr_t;

    // Attr 3:0 fix colour, 5:4 ROM bank, whole byte scroll colour
    typedef struct packed {
        logic [7:0] attr;
        logic [7:0] code;
    } map_entry_t;

    // Bank, code, tile row
    typedef logic [12:0] rom_addr_t;
    // Eight nibbles, leftmost pixel on top
    typedef logic [31:0] rom_data_t;

    // Colour above pixel nibble
    typedef logic [7:0]  fix_pxl_t;
    typedef logic [11:0] scr_pxl_t;

    typedef logic [12:0] cpu_addr_t;

    localparam cpu_addr_t fix_base    = 13'h0000;
    localparam cpu_addr_t scr_base    = 13'h0800;
    localparam cpu_addr_t reg_hscr_lo = 13'h1000;
    localparam cpu_addr_t reg_hscr_hi = 13'h1001;
    localparam cpu_addr_t reg_vscr    = 13'h1002;
    localparam cpu_addr_t reg_ctrl    = 13'h1003;

    // Pixels between fetch column and draw column
    localparam int fetch_lead = 8;

endpackage

//--- logic/scan_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan interface
// Pixel strobe, raster position and scroll values that the
// control block hands to both tile layers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface scan_if
    import tscroll_pkg::*;
();
    logic       pxl_cen;
    hpos_t      hdump;
    vpos_t      vdump;
    // Nine bits horizontal, eight vertical
    logic [8:0] hscroll;
    logic [7:0] vscroll;

    modport ctrl  (output pxl_cen, hdump, vdump, hscroll, vscroll);
    modport layer (input  pxl_cen, hdump, vdump, hscroll, vscroll);
endinterface

//--- logic/cpu_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU byte port of one tilemap RAM
// Window-local address, write data and strobe, read byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface cpu_bus_if;
    // Byte offset inside the 2 KiB window
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        we;
    // Valid one clk after addr
    logic [7:0]  rdata;

    modport host (output addr, wdata, we, input rdata);
    modport mem  (input addr, wdata, we, output rdata);
endinterface

//--- logic/video_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video control block
// Raster counters, sync and blanking, CPU decode into the two
// tilemap windows and the scroll/control registers, vblank IRQ
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module video_ctrl
    import tscroll_pkg::*;
#(
    parameter int h_active = 256,
    parameter int h_total  = 384,
    parameter int v_active = 224,
    parameter int v_total  = 264
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  cpu_addr_t  cpu_addr,
    input  logic [7:0] cpu_dout,
    input  logic       cpu_we,
    output logic [7:0] tilemap_dout,
    output hpos_t      hdump,
    output vpos_t      vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       irq_n,
    scan_if.ctrl       scan,
    cpu_bus_if.host    fix_bus,
    cpu_bus_if.host    scr_bus
);
    localparam hpos_t h_last   = hpos_t'(h_total - 1);
    localparam vpos_t v_last   = vpos_t'(v_total - 1);
    localparam hpos_t h_act    = hpos_t'(h_active);
    localparam vpos_t v_act    = vpos_t'(v_active);
    // Sync windows sit a little after the active area
    localparam hpos_t hs_start = hpos_t'(h_active + 8);
    localparam hpos_t hs_end   = hpos_t'(h_active + 16);
    localparam vpos_t vs_start = vpos_t'(v_active + 2);
    localparam vpos_t vs_end   = vpos_t'(v_active + 4);
    // Line before vblank starts
    localparam vpos_t v_irq    = vpos_t'(v_active - 1);

    logic       h_wrap;
    logic       in_fix;
    logic       in_scr;
    logic       rd_fix;
    logic       rd_scr;
    logic       irq_en;
    logic       irq_pend;
    logic [8:0] hscr;
    logic [7:0] vscr;

    assign h_wrap = hdump == h_last;

    // Raster counters, advanced by the pixel strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            hdump <= h_wrap ? '0 : hdump + 1'b1;
            if (h_wrap) begin
                vdump <= (vdump == v_last) ? '0 : vdump + 1'b1;
            end
        end
    end

    // Blanking and sync straight from the counters
    assign lhbl = hdump < h_act;
    assign lvbl = vdump < v_act;
    assign hs   = (hdump >= hs_start) && (hdump < hs_end);
    assign vs   = (vdump >= vs_start) && (vdump < vs_end);

    // Window decode on the top address bits
    assign in_fix = cpu_addr[12:11] == fix_base[12:11];
    assign in_scr = cpu_addr[12:11] == scr_base[12:11];

    assign fix_bus.addr  = cpu_addr[10:0];
    assign fix_bus.wdata = cpu_dout;
    assign fix_bus.we    = cpu_we && in_fix;
    assign scr_bus.addr  = cpu_addr[10:0];
    assign scr_bus.wdata = cpu_dout;
    assign scr_bus.we    = cpu_we && in_scr;

    // Scroll and control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hscr   <= '0;
            vscr   <= '0;
            irq_en <= 1'b0;
        end else if (cpu_we) begin
            case (cpu_addr)
                reg_hscr_lo: hscr[7:0] <= cpu_dout;
                reg_hscr_hi: hscr[8]   <= cpu_dout[0];
                reg_vscr:    vscr      <= cpu_dout;
                reg_ctrl:    irq_en    <= cpu_dout[0];
                default: ;
            endcase
        end
    end

    // Pending on entry to vblank, any reg_ctrl write acks it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_pend <= 1'b0;
        end else if (pxl_cen && h_wrap && vdump == v_irq && irq_en) begin
            irq_pend <= 1'b1;
        end else if (cpu_we && cpu_addr == reg_ctrl) begin
            irq_pend <= 1'b0;
        end
    end

    assign irq_n = ~irq_pend;

    // Remember which window the RAM data belongs to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_fix <= 1'b0;
            rd_scr <= 1'b0;
        end else begin
            rd_fix <= in_fix;
            rd_scr <= in_scr;
        end
    end

    // Register space reads back as zero
    assign tilemap_dout = rd_fix ? fix_bus.rdata :
                          rd_scr ? scr_bus.rdata : 8'h00;

    assign scan.pxl_cen = pxl_cen;
    assign scan.hdump   = hdump;
    assign scan.vdump   = vdump;
    assign scan.hscroll = hscr;
    assign scan.vscroll = vscr;

endmodule

//--- logic/tilemap_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tilemap RAM
// 2 KiB, byte wide on the CPU side, 1024 code/attr entries
// on the video side, both ports read synchronously
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tilemap_ram
    import tscroll_pkg::*;
(
    input  logic       clk,
    input  map_addr_t  vid_addr,
    output map_entry_t vid_entry,
    cpu_bus_if.mem     bus
);
    // Even bytes hold codes, odd bytes attributes
    logic [7:0] code_mem [1024];
    logic [7:0] attr_mem [1024];

    map_addr_t cpu_idx;

    assign cpu_idx = bus.addr[10:1];

    // CPU byte port
    always_ff @(posedge clk) begin
        if (bus.we) begin
            if (bus.addr[0]) begin
                attr_mem[cpu_idx] <= bus.wdata;
            end else begin
                code_mem[cpu_idx] <= bus.wdata;
            end
        end
        // Old data on a same-cycle write
        bus.rdata <= bus.addr[0] ? attr_mem[cpu_idx] : code_mem[cpu_idx];
    end

    // Video port, whole entry one clk after the address
    always_ff @(posedge clk) begin
        vid_entry.code <= code_mem[vid_addr];
        vid_entry.attr <= attr_mem[vid_addr];
    end

endmodule

//--- logic/layer_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile layer fetch
// Map position from scan and scroll, entry latch at each tile
// boundary, tile ROM address and the delayed load strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module layer_fetch
    import tscroll_pkg::*;
#(
    parameter bit has_scroll = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    scan_if.layer      scan,
    input  map_entry_t vid_entry,
    output map_addr_t  vid_addr,
    output rom_addr_t  rom_addr,
    output logic       load,
    output logic [7:0] color
);
    logic [8:0] hoff;
    logic [7:0] voff;
    logic [8:0] col_sum;
    logic [8:0] row_sum;
    logic [7:0] fcol;
    logic [7:0] frow;
    logic       tile_start;
    logic [fetch_lead-1:0] ld_dly;

    // Fix layer ignores the scroll registers
    assign hoff = has_scroll ? scan.hscroll : 9'd0;
    assign voff = has_scroll ? scan.vscroll : 8'd0;

    // Map is 256 pixels each way, so keep the low byte
    assign col_sum = scan.hdump + 9'(fetch_lead) + hoff;
    assign row_sum = scan.vdump + 9'(voff);
    assign fcol    = col_sum[7:0];
    assign frow    = row_sum[7:0];

    // Address stays put for a whole pixel, entry is ready by the strobe
    assign vid_addr   = {frow[7:3], fcol[7:3]};
    assign tile_start = fcol[2:0] == 3'd0;

    // Entry latch, held for the eight pixels the ROM may take
    always_ff @(posedge clk) begin
        if (scan.pxl_cen && tile_start) begin
            rom_addr <= {vid_entry.attr[5:4], vid_entry.code, frow[2:0]};
            color    <= vid_entry.attr;
        end
    end

    // Load arrives fetch_lead pixels after the fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_dly <= '0;
        end else if (scan.pxl_cen) begin
            ld_dly <= {ld_dly[fetch_lead-2:0], tile_start};
        end
    end

    // High from the pixel before the load strobe
    assign load = ld_dly[fetch_lead-1];

endmodule

//--- logic/layer_draw.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile layer draw
// Eight-pixel shifter with colour, one nibble per pixel strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module layer_draw
    import tscroll_pkg::*;
#(
    parameter type pxl_t = fix_pxl_t
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       load,
    input  logic [7:0] color,
    input  rom_data_t  rom_data,
    output pxl_t       pxl,
    output logic       blnk_n
);
    // Colour bits that fit above the nibble
    localparam int cw = $bits(pxl_t) - 4;

    rom_data_t       shift;
    logic [cw-1:0]   col;

    // Tile row shifter and colour
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (load) begin
                shift <= rom_data << 4;
                col   <= color[cw-1:0];
            end else begin
                shift <= shift << 4;
            end
        end
    end

    // First pixel of a new tile goes out on the load strobe itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (load) begin
                pxl <= pxl_t'({color[cw-1:0], rom_data[31:28]});
            end else begin
                pxl <= pxl_t'({col, shift[31:28]});
            end
        end
    end

    // Nibble zero is transparent
    assign blnk_n = pxl[3:0] != 4'd0;

endmodule

//--- logic/tile_scroll.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile-scroll video top
// Control block, fix and scroll tilemap RAMs, fetch and draw
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tile_scroll
    import tscroll_pkg::*;
#(
    parameter int h_active = 256,
    parameter int h_total  = 384,
    parameter int v_active = 224,
    parameter int v_total  = 264
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  cpu_addr_t  cpu_addr,
    input  logic [7:0] cpu_dout,
    input  logic       cpu_we,
    input  rom_data_t  fix_data,
    input  rom_data_t  scr_data,
    output logic [7:0] tilemap_dout,
    output hpos_t      hdump,
    output vpos_t      vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       irq_n,
    output rom_addr_t  fix_addr,
    output rom_addr_t  scr_addr,
    output fix_pxl_t   fix_pxl,
    output scr_pxl_t   scr_pxl,
    output logic       fix_blnk_n,
    output logic       scr_blnk_n
);
    map_addr_t  fix_vid_addr;
    map_addr_t  scr_vid_addr;
    map_entry_t fix_entry;
    map_entry_t scr_entry;
    logic       fix_load;
    logic       scr_load;
    logic [7:0] fix_color;
    logic [7:0] scr_color;

    scan_if    u_scan ();
    cpu_bus_if fix_bus ();
    cpu_bus_if scr_bus ();

    video_ctrl #(
        .h_active ( h_active ),
        .h_total  ( h_total  ),
        .v_active ( v_active ),
        .v_total  ( v_total  )
    ) u_ctrl (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .cpu_we       ( cpu_we       ),
        .tilemap_dout ( tilemap_dout ),
        .hdump        ( hdump        ),
        .vdump        ( vdump        ),
        .lhbl         ( lhbl         ),
        .lvbl         ( lvbl         ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .irq_n        ( irq_n        ),
        .scan         ( u_scan       ),
        .fix_bus      ( fix_bus      ),
        .scr_bus      ( scr_bus      )
    );

    // Fix layer, no scroll, four colour bits
    tilemap_ram u_fix_ram (
        .clk       ( clk          ),
        .vid_addr  ( fix_vid_addr ),
        .vid_entry ( fix_entry    ),
        .bus       ( fix_bus      )
    );

    layer_fetch #(.has_scroll(1'b0)) u_fix_fetch (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .scan      ( u_scan       ),
        .vid_entry ( fix_entry    ),
        .vid_addr  ( fix_vid_addr ),
        .rom_addr  ( fix_addr     ),
        .load      ( fix_load     ),
        .color     ( fix_color    )
    );

    layer_draw #(.pxl_t(fix_pxl_t)) u_fix_draw (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .pxl_cen  ( pxl_cen    ),
        .load     ( fix_load   ),
        .color    ( fix_color  ),
        .rom_data ( fix_data   ),
        .pxl      ( fix_pxl    ),
        .blnk_n   ( fix_blnk_n )
    );

    // Scroll layer, full attribute byte as colour
    tilemap_ram u_scr_ram (
        .clk       ( clk          ),
        .vid_addr  ( scr_vid_addr ),
        .vid_entry ( scr_entry    ),
        .bus       ( scr_bus      )
    );

    layer_fetch #(.has_scroll(1'b1)) u_scr_fetch (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .scan      ( u_scan       ),
        .vid_entry ( scr_entry    ),
        .vid_addr  ( scr_vid_addr ),
        .rom_addr  ( scr_addr     ),
        .load      ( scr_load     ),
        .color     ( scr_color    )
    );

    layer_draw #(.pxl_t(scr_pxl_t)) u_scr_draw (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .pxl_cen  ( pxl_cen    ),
        .load     ( scr_load   ),
        .color    ( scr_color  ),
        .rom_data ( scr_data   ),
        .pxl      ( scr_pxl    ),
        .blnk_n   ( scr_blnk_n )
    );

endmodule

//--- testbench/tb_tile_scroll.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile-scroll video testbench
// Raster counters, map read-back, fix and scroll pixels
// against a reference model, vblank interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_tile_scroll
    import tscroll_pkg::*;
();
    localparam int h_active   = 64;
    localparam int h_total    = 96;
    localparam int v_active   = 16;
    localparam int v_total    = 24;
    // Two clk per pixel plus some slack
    localparam int frame_clks = 2 * h_total * v_total + 64;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen  = 1'b0;
    cpu_addr_t  cpu_addr;
    logic [7:0] cpu_dout;
    logic       cpu_we;
    rom_data_t  fix_data = '0;
    rom_data_t  scr_data = '0;
    logic [7:0] tilemap_dout;
    hpos_t      hdump;
    vpos_t      vdump;
    logic       lhbl;
    logic       lvbl;
    logic       hs;
    logic       vs;
    logic       irq_n;
    rom_addr_t  fix_addr;
    rom_addr_t  scr_addr;
    fix_pxl_t   fix_pxl;
    scr_pxl_t   scr_pxl;
    logic       fix_blnk_n;
    logic       scr_blnk_n;

    // Shadow state of the DUT
    logic [7:0]  fix_map [2048];
    logic [7:0]  scr_map [2048];
    // Map column wraps at 256 so only the low hscroll byte matters
    logic [7:0]  hscr_sh = '0;
    logic [7:0]  vscr_sh = '0;
    logic [31:0] lfsr = 32'h77a8;
    // Pixel strobe as the DUT saw it on the last edge
    logic        cen_seen = 1'b0;
    bit          check_on = 1'b0;
    hpos_t       h_exp;
    vpos_t       v_exp;

    tile_scroll #(
        .h_active ( h_active ),
        .h_total  ( h_total  ),
        .v_active ( v_active ),
        .v_total  ( v_total  )
    ) i_dut (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_dout     ( cpu_dout     ),
        .cpu_we       ( cpu_we       ),
        .fix_data     ( fix_data     ),
        .scr_data     ( scr_data     ),
        .tilemap_dout ( tilemap_dout ),
        .hdump        ( hdump        ),
        .vdump        ( vdump        ),
        .lhbl         ( lhbl         ),
        .lvbl         ( lvbl         ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .irq_n        ( irq_n        ),
        .fix_addr     ( fix_addr     ),
        .scr_addr     ( scr_addr     ),
        .fix_pxl      ( fix_pxl      ),
        .scr_pxl      ( scr_pxl      ),
        .fix_blnk_n   ( fix_blnk_n   ),
        .scr_blnk_n   ( scr_blnk_n   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Pixel strobe every other clk and quiet in reset
    always @(posedge clk) begin
        pxl_cen  <= rst_n ? ~pxl_cen : 1'b0;
        cen_seen <= pxl_cen;
    end

    // One Fibonacci step with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Tile ROM word with two transparent nibbles per row
    function automatic rom_data_t rom_word(input rom_addr_t a);
        rom_data_t w;
        rom_data_t mask;
        w    = (32'(a) * 32'h9e37_79b9) ^ 32'h3c5a_0f96;
        mask = 32'h0000_000f << {a[1:0], 2'b00};
        mask = mask | (mask << 16);
        return w & ~mask;
    endfunction

    // ROM answers one clk after the address
    always @(posedge clk) begin
        fix_data <= rom_word(fix_addr);
        scr_data <= rom_word(scr_addr);
    end

    // Reference pixel as attribute byte above the nibble at map (col, row)
    function automatic logic [11:0] map_pixel(input bit scroll_map,
                                              input logic [7:0] col,
                                              input logic [7:0] row);
        logic [10:0] code_idx;
        logic [10:0] attr_idx;
        logic [7:0]  code;
        logic [7:0]  attr;
        rom_data_t   word;
        code_idx = {row[7:3], col[7:3], 1'b0};
        attr_idx = {row[7:3], col[7:3], 1'b1};
        code     = scroll_map ? scr_map[code_idx] : fix_map[code_idx];
        attr     = scroll_map ? scr_map[attr_idx] : fix_map[attr_idx];
        word     = rom_word({attr[5:4], code, row[2:0]});
        // Leftmost pixel sits in the top nibble
        word     = word << {col[2:0], 2'b00};
        return {attr, word[31:28]};
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_hpos(input string name, input hpos_t got, input hpos_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_vpos(input string name, input vpos_t got, input vpos_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_fix(input string name, input fix_pxl_t got, input fix_pxl_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_scr(input string name, input scr_pxl_t got, input scr_pxl_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Raster counters, sync and blanking on every pixel strobe
    always @(negedge clk) begin
        if (!rst_n) begin
            h_exp = '0;
            v_exp = '0;
        end else if (cen_seen) begin
            if (h_exp == hpos_t'(h_total - 1)) begin
                h_exp = '0;
                v_exp = (v_exp == vpos_t'(v_total - 1)) ? '0 : v_exp + 1'b1;
            end else begin
                h_exp = h_exp + 1'b1;
            end
            check_hpos("hdump", hdump, h_exp);
            check_vpos("vdump", vdump, v_exp);
            check_bit("lhbl", lhbl, h_exp < hpos_t'(h_active));
            check_bit("lvbl", lvbl, v_exp < vpos_t'(v_active));
            check_bit("hs", hs, h_exp >= hpos_t'(h_active + 8) &&
                                h_exp <  hpos_t'(h_active + 16));
            check_bit("vs", vs, v_exp >= vpos_t'(v_active + 2) &&
                                v_exp <  vpos_t'(v_active + 4));
        end
    end

    // Pixel register trails hdump by one column
    always @(negedge clk) begin : pixel_cmp
        logic [7:0]  col;
        logic [7:0]  row;
        logic [11:0] exp_pxl;
        if (check_on && cen_seen && hdump >= hpos_t'(16) &&
            hdump < hpos_t'(h_active) && vdump < vpos_t'(v_active)) begin
            col     = hdump[7:0] - 8'd1;
            row     = vdump[7:0];
            exp_pxl = map_pixel(1'b0, col, row);
            check_fix("fix_pxl", fix_pxl, fix_pxl_t'(exp_pxl[7:0]));
            check_bit("fix_blnk_n", fix_blnk_n, exp_pxl[3:0] != 4'd0);
            col     = col + hscr_sh;
            row     = row + vscr_sh;
            exp_pxl = map_pixel(1'b1, col, row);
            check_scr("scr_pxl", scr_pxl, exp_pxl);
            check_bit("scr_blnk_n", scr_blnk_n, exp_pxl[3:0] != 4'd0);
        end
    end

    task automatic cpu_write(input cpu_addr_t a, input logic [7:0] d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_we   <= 1'b1;
        @(posedge clk);
        cpu_we   <= 1'b0;
    endtask

    // Byte is on tilemap_dout one clk after the address
    task automatic read_expect(input cpu_addr_t a, input logic [7:0] exp);
        @(posedge clk);
        cpu_addr <= a;
        cpu_we   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_byte("tilemap_dout", tilemap_dout, exp);
    endtask

    task automatic wait_raster(input hpos_t h, input vpos_t v, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(hdump == h && vdump == v)) begin
            if (cycles == limit) begin
                $display("timeout waiting for raster position %0d, line %0d", h, v);
                stop_on_error();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Random bytes into one map window and its shadow
    task automatic fill_window(input bit scroll_map);
        logic [31:0] r;
        logic [10:0] idx;
        cpu_addr_t   base;
        base = scroll_map ? scr_base : fix_base;
        for (int i = 0; i < 2048; i++) begin
            idx = 11'(i);
            r   = take_bits(8);
            cpu_write(base + cpu_addr_t'(idx), r[7:0]);
            if (scroll_map) begin
                scr_map[idx] = r[7:0];
            end else begin
                fix_map[idx] = r[7:0];
            end
        end
    endtask

    task automatic verify_window(input bit scroll_map);
        logic [10:0] idx;
        cpu_addr_t   base;
        base = scroll_map ? scr_base : fix_base;
        for (int i = 0; i < 2048; i++) begin
            idx = 11'(i);
            read_expect(base + cpu_addr_t'(idx), scroll_map ? scr_map[idx] : fix_map[idx]);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          cycles;
        rst_n    = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_we   = 1'b0;

        // Outputs while held in reset
        @(posedge clk);
        @(negedge clk);
        check_hpos("hdump", hdump, '0);
        check_vpos("vdump", vdump, '0);
        check_bit("irq_n", irq_n, 1'b1);
        check_bit("lhbl", lhbl, 1'b1);
        check_bit("lvbl", lvbl, 1'b1);
        check_bit("hs", hs, 1'b0);
        check_bit("vs", vs, 1'b0);
        check_bit("fix_blnk_n", fix_blnk_n, 1'b0);
        check_bit("scr_blnk_n", scr_blnk_n, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;

        // One full frame of counter checks
        wait_raster(hpos_t'(h_total - 1), vpos_t'(v_total - 1), frame_clks);
        wait_raster(hpos_t'(0), vpos_t'(0), frame_clks);

        // Map windows read back
        fill_window(1'b0);
        fill_window(1'b1);
        verify_window(1'b0);
        verify_window(1'b1);

        // Pixels with zero scroll over a whole frame
        wait_raster(hpos_t'(0), vpos_t'(0), frame_clks);
        check_on = 1'b1;
        wait_raster(hpos_t'(0), vpos_t'(v_active), frame_clks);

        // New scroll values in vblank with the ninth bit set in the first round
        for (int round = 0; round < 3; round++) begin
            wait_raster(hpos_t'(0), vpos_t'(v_active + 1), frame_clks);
            r = take_bits(8);
            cpu_write(reg_hscr_lo, r[7:0]);
            hscr_sh = r[7:0];
            r = take_bits(7);
            cpu_write(reg_hscr_hi, {r[6:0], ~round[0]});
            r = take_bits(8);
            cpu_write(reg_vscr, r[7:0]);
            vscr_sh = r[7:0];
            wait_raster(hpos_t'(0), vpos_t'(0), frame_clks);
            wait_raster(hpos_t'(0), vpos_t'(v_active), frame_clks);
        end

        // Register space reads zero while the registers hold nonzero values
        read_expect(reg_hscr_lo, 8'h00);
        read_expect(reg_hscr_hi, 8'h00);
        read_expect(reg_vscr, 8'h00);

        // IRQ enabled and high until vblank starts
        wait_raster(hpos_t'(0), vpos_t'(2), frame_clks);
        cpu_write(reg_ctrl, 8'h01);
        read_expect(reg_ctrl, 8'h00);
        @(negedge clk);
        cycles = 0;
        while (vdump != vpos_t'(v_active)) begin
            if (cycles == frame_clks) begin
                $display("timeout waiting for vblank with the interrupt enabled");
                stop_on_error();
            end
            check_bit("irq_n", irq_n, 1'b1);
            cycles++;
            @(negedge clk);
        end
        check_bit("irq_n", irq_n, 1'b0);

        // Held low across the frame wrap until acknowledged
        cycles = 0;
        while (vdump != vpos_t'(1)) begin
            if (cycles == frame_clks) begin
                $display("timeout waiting for line 1 with the interrupt pending");
                stop_on_error();
            end
            check_bit("irq_n", irq_n, 1'b0);
            cycles++;
            @(negedge clk);
        end
        cpu_write(reg_ctrl, 8'h00);
        @(negedge clk);
        check_bit("irq_n", irq_n, 1'b1);

        // No interrupt over a whole frame with the enable clear
        for (int n = 0; n < frame_clks; n++) begin
            @(negedge clk);
            check_bit("irq_n", irq_n, 1'b1);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src.f
logic/tscroll_pkg.sv
logic/scan_if.sv
logic/cpu_bus_if.sv
logic/video_ctrl.sv
logic/tilemap_ram.sv
logic/layer_fetch.sv
logic/layer_draw.sv
logic/tile_scroll.sv
testbench/tb_tile_scroll.sv

//--- Makefile
# Verilator build and run of the tile-scroll testbench
TOP = tb_tile_scroll

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f src.f --Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
